// File: Bender.yml
package:
  name: bcfg

sources:
  - files:
      - verilog/bcfg_pkg.sv
      - verilog/snapshot_if.sv
      - verilog/bcfg_regs.sv
      - verilog/bcfg_sampler.sv
      - verilog/bcfg_top.sv
  - target: test
    files:
      - verification/bcfg_properties.sv
      - verification/bcfg_tb.sv

// File: flist.f
verilog/bcfg_pkg.sv
verilog/snapshot_if.sv
verilog/bcfg_regs.sv
verilog/bcfg_sampler.sv
verilog/bcfg_top.sv
verification/bcfg_properties.sv
verification/bcfg_tb.sv

// File: verification/bcfg_properties.sv
// Bound checks on reset state, sampler busy width and host write strobes
`default_nettype none

module bcfg_properties #(
    parameter int NUM_RT_READ_QUADS = 4
) (
    input logic sysclk,
    input logic arst_n,
    input logic sample_busy,
    input logic led,
    input logic reg_wen,
    input logic blk_wen
);

    localparam int NUM_ENTRIES = 1 + NUM_RT_READ_QUADS;  // Sequence word plus quadlets

    // Outputs idle while reset is held and on release
    a_reset_idle: assert property (@(posedge sysclk) !arst_n |-> !sample_busy && !led)
        else $error("sampler busy or led set while in reset");
    a_release_idle: assert property (@(posedge sysclk) $rose(arst_n) |-> !sample_busy && !led)
        else $error("sampler busy or led set right after reset release");

    // One cycle per buffer entry, then idle
    a_busy_width: assert property (@(posedge sysclk) disable iff (!arst_n)
        $rose(sample_busy) |-> sample_busy [*NUM_ENTRIES] ##1 !sample_busy)
        else $error("sample_busy width differs from the number of entries");

    a_strobe_excl: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(reg_wen && blk_wen))
        else $error("reg_wen and blk_wen high in the same cycle");

endmodule

`default_nettype wire

// File: verification/bcfg_tb.sv
// Testbench for the boot configuration subsystem, acting as the register bus host
`default_nettype none

module bcfg_tb;

    localparam int NUM_RT_READ_QUADS = 4;
    localparam int TIMEOUT_CYCLES    = 2000;  // Full run is near 170 cycles

    logic                  sysclk = 1'b0;
    logic                  arst_n;
    logic [3:0]            wenid;
    bcfg_pkg::quad_t       io_in;
    logic [15:0]           reg_raddr;
    logic [15:0]           reg_waddr;
    bcfg_pkg::quad_t       reg_rdata;
    bcfg_pkg::quad_t       reg_wdata;
    logic                  reg_wen;
    logic                  blk_wstart;
    logic                  blk_wen;
    logic                  sample_start;
    logic                  sample_busy;
    logic [5:0]            sample_raddr;
    bcfg_pkg::quad_t       sample_rdata;
    logic [63:0]           reg_emio;
    logic                  led;

    // Reference state
    logic [3:0]            m_board_id;
    logic                  m_led;
    logic [15:0]           m_emio;
    logic [15:0]           m_seq;
    bcfg_pkg::quad_t       m_io_in;
    bcfg_pkg::quad_t       m_scratch [4];

    logic [31:0]           lfsr;
    int                    cycle_cnt = 0;
    int                    n_posted  = 0;
    int                    n_checked = 0;
    string                 name_q [$];  // Pending checks
    logic [63:0]           exp_q [$];
    logic [63:0]           act_q [$];

    bcfg_top #(
        .NUM_RT_READ_QUADS (NUM_RT_READ_QUADS)
    ) dut (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .wenid        (wenid),
        .io_in        (io_in),
        .reg_emio     (reg_emio),
        .led          (led),
        .reg_raddr    (reg_raddr),
        .reg_rdata    (reg_rdata),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wstart   (blk_wstart),
        .blk_wen      (blk_wen),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata)
    );

    bind bcfg_top bcfg_properties #(
        .NUM_RT_READ_QUADS (NUM_RT_READ_QUADS)
    ) u_props (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .sample_busy (sample_busy),
        .led         (led),
        .reg_wen     (reg_wen),
        .blk_wen     (blk_wen)
    );

    always #20 sysclk = ~sysclk;  // Period 40

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // Galois step, taps 32,30,26,25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output bcfg_pkg::quad_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);  // One step per bit
        end
    endtask

    // Expected register read from the address map
    function automatic bcfg_pkg::quad_t reg_model(input logic [15:0] addr, input logic busy);
        bcfg_pkg::quad_t v;
        v = '0;  // Unmapped reads 0
        if (addr == bcfg_pkg::REG_STATUS) begin
            v[3:0]   = m_board_id;
            v[4]     = m_led;
            v[5]     = busy;
            v[31:24] = bcfg_pkg::FW_VERSION;
        end else if (addr == bcfg_pkg::REG_CONTROL) begin
            v = {m_emio, 15'd0, m_led};
        end else if (addr == bcfg_pkg::REG_IO_IN) begin
            v = m_io_in;
        end else if (addr >= 16'd4 && addr < 16'd8) begin
            v = m_scratch[int'(addr) - 4];
        end
        return v;
    endfunction

    // Expected buffer entry; timestamp entry compared by difference
    function automatic bcfg_pkg::quad_t snapshot_model(input int idx);
        case (idx)
            0:       return {m_seq, 12'd0, m_board_id};
            2:       return m_io_in;
            3:       return reg_model(bcfg_pkg::REG_STATUS, 1'b1);  // Captured while busy
            4:       return m_scratch[0];
            default: return '0;
        endcase
    endfunction

    task automatic reg_write(input logic [15:0] addr, input bcfg_pkg::quad_t data);
        @(negedge sysclk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen = 1'b0;
    endtask

    task automatic reg_read(input logic [15:0] addr, output bcfg_pkg::quad_t data);
        @(negedge sysclk);
        reg_raddr = addr;
        @(negedge sysclk);  // One edge of read latency
        data = reg_rdata;
    endtask

    task automatic buf_read(input int idx, output bcfg_pkg::quad_t data);
        @(negedge sysclk);
        sample_raddr = 6'(idx);
        @(negedge sysclk);
        data = sample_rdata;
    endtask

    // Start pulse, optional second pulse while busy, busy length in cycles
    task automatic run_sample(input bit extra_pulse, output int busy_len, output int start_cyc);
        @(negedge sysclk);
        sample_start = 1'b1;
        start_cyc    = cycle_cnt;
        @(negedge sysclk);
        sample_start = extra_pulse;
        busy_len     = 0;
        while (sample_busy) begin
            busy_len++;
            @(negedge sysclk);
            sample_start = 1'b0;
        end
    endtask

    task automatic post_check(input string name, input logic [63:0] exp, input logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
        n_posted++;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    initial begin : compare
        string       name;
        logic [63:0] exp;
        logic [63:0] act;
        forever begin
            wait (n_posted > n_checked);
            name = name_q.pop_front();
            exp  = exp_q.pop_front();
            act  = act_q.pop_front();
            check_val(name, exp, act);
            n_checked++;
        end
    end

    initial begin : stimulus
        bcfg_pkg::quad_t rd;
        bcfg_pkg::quad_t w;
        bcfg_pkg::quad_t ts [3];
        int              tcyc [3];
        int              busy_len;

        lfsr         = 32'h7ebc_69b4;
        arst_n       = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wstart   = 1'b0;
        blk_wen      = 1'b0;
        sample_start = 1'b0;
        sample_raddr = '0;
        rand_bits(4, w);
        wenid      = w[3:0];
        m_board_id = ~w[3:0];  // Switch is active low
        rand_bits(32, w);
        io_in   = w;
        m_io_in = w;
        m_led   = 1'b0;
        m_emio  = '0;
        m_seq   = '0;
        for (int i = 0; i < 4; i++) begin
            m_scratch[i] = '0;
        end
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        arst_n = 1'b1;

        // Reset values, timestamp skipped
        for (int a = 0; a < 8; a++) begin
            if (a != 3) begin
                reg_read(16'(a), rd);
                post_check($sformatf("reset_reg%0d", a), reg_model(16'(a), 1'b0), rd);
            end
        end
        post_check("reset_led", 64'(m_led), 64'(led));
        post_check("reset_emio", 64'd0, reg_emio);
        post_check("reset_busy", 64'd0, 64'(sample_busy));

        // Single writes
        rand_bits(32, w);
        reg_write(bcfg_pkg::REG_CONTROL, w);
        m_led  = w[0];
        m_emio = w[31:16];
        reg_read(bcfg_pkg::REG_CONTROL, rd);
        post_check("ctrl_read", reg_model(bcfg_pkg::REG_CONTROL, 1'b0), rd);
        post_check("ctrl_led", 64'(m_led), 64'(led));
        post_check("ctrl_emio", {48'd0, m_emio}, reg_emio);
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, w);
            reg_write(16'(4 + i), w);
            m_scratch[i] = w;
        end
        for (int i = 0; i < 4; i++) begin
            reg_read(16'(4 + i), rd);
            post_check($sformatf("scratch%0d", i), reg_model(16'(4 + i), 1'b0), rd);
        end
        rand_bits(32, w);
        reg_write(bcfg_pkg::REG_STATUS, w);  // Read-only and unmapped, all ignored
        reg_write(bcfg_pkg::REG_IO_IN, w);
        reg_write(bcfg_pkg::REG_TIMESTAMP, w);
        reg_write(16'h0104, w);  // Aliases scratch0 on a partial decode
        reg_read(bcfg_pkg::REG_STATUS, rd);
        post_check("ro_status", reg_model(bcfg_pkg::REG_STATUS, 1'b0), rd);
        reg_read(bcfg_pkg::REG_IO_IN, rd);
        post_check("ro_io_in", reg_model(bcfg_pkg::REG_IO_IN, 1'b0), rd);
        reg_read(16'h0104, rd);
        post_check("unmapped", 64'd0, rd);
        // Control and scratch untouched
        reg_read(bcfg_pkg::REG_CONTROL, rd);
        post_check("ro_ctrl", reg_model(bcfg_pkg::REG_CONTROL, 1'b0), rd);
        for (int i = 0; i < 4; i++) begin
            reg_read(16'(4 + i), rd);
            post_check($sformatf("ro_scratch%0d", i), reg_model(16'(4 + i), 1'b0), rd);
        end

        // Block write from address 3, first word dropped
        @(negedge sysclk);
        reg_waddr  = bcfg_pkg::REG_TIMESTAMP;
        blk_wstart = 1'b1;
        @(negedge sysclk);
        blk_wstart = 1'b0;
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, w);
            reg_wdata = w;
            blk_wen   = 1'b1;
            if (i > 0) begin
                m_scratch[i - 1] = w;
            end
            @(negedge sysclk);
        end
        blk_wen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            reg_read(16'(4 + i), rd);
            post_check($sformatf("blk_scratch%0d", i), reg_model(16'(4 + i), 1'b0), rd);
        end

        // Timestamp delta and input register
        reg_read(bcfg_pkg::REG_TIMESTAMP, ts[0]);
        tcyc[0] = cycle_cnt;
        rand_bits(3, w);
        repeat (int'(w[2:0]) + 1) @(negedge sysclk);
        reg_read(bcfg_pkg::REG_TIMESTAMP, ts[1]);
        tcyc[1] = cycle_cnt;
        post_check("ts_delta", 64'(32'(tcyc[1] - tcyc[0])), 64'(ts[1] - ts[0]));
        @(negedge sysclk);
        rand_bits(32, w);
        io_in   = w;
        m_io_in = w;
        reg_read(bcfg_pkg::REG_IO_IN, rd);
        post_check("io_in_read", reg_model(bcfg_pkg::REG_IO_IN, 1'b0), rd);

        // Samples, the second one with a start pulse while busy
        for (int s = 0; s < 3; s++) begin
            run_sample(s == 1, busy_len, tcyc[s]);
            m_seq = m_seq + 16'd1;
            post_check($sformatf("busy_len%0d", s), 64'(1 + NUM_RT_READ_QUADS), 64'(busy_len));
            for (int e = 0; e <= NUM_RT_READ_QUADS; e++) begin
                buf_read(e, rd);
                if (e == 1) begin
                    ts[s] = rd;
                end else begin
                    post_check($sformatf("sample%0d_entry%0d", s, e), snapshot_model(e), rd);
                end
            end
            if (s > 0) begin
                post_check($sformatf("sample%0d_ts_gap", s),
                           64'(32'(tcyc[s] - tcyc[s - 1])), 64'(ts[s] - ts[s - 1]));
            end
            rand_bits(3, w);
            repeat (int'(w[2:0])) @(negedge sysclk);
        end

        wait (n_checked == n_posted);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bcfg_pkg.sv
// Shared types and address map of the boot configuration subsystem
`default_nettype none

package bcfg_pkg;

    // One register or buffer word
    typedef logic [31:0] quad_t;

    // Bus widths
    localparam int ADDR_W        = 16;  // Host register address
    localparam int SAMPLE_ADDR_W = 6;   // Sample buffer address, 64 quadlets

    // Register address map
    localparam logic [ADDR_W-1:0] REG_STATUS    = 16'd0;  // Read only
    localparam logic [ADDR_W-1:0] REG_CONTROL   = 16'd1;  // LED and EMIO
    localparam logic [ADDR_W-1:0] REG_IO_IN     = 16'd2;  // Read only
    localparam logic [ADDR_W-1:0] REG_TIMESTAMP = 16'd3;  // Read only

    // Scratch quadlets sit right after the fixed registers
    localparam logic [ADDR_W-1:0] REG_SCRATCH_BASE = 16'd4;
    localparam int                NUM_SCRATCH      = 4;   // Addresses 4..7

    // Firmware version, top byte of status
    localparam logic [7:0] FW_VERSION = 8'h09;

    // Rotary switch width
    localparam int BOARD_ID_W = 4;

    // Status word layout
    localparam int STATUS_BOARD_ID_LSB = 0;   // 4-bit board id
    localparam int STATUS_LED_BIT      = 4;   // Mirrors control LED
    localparam int STATUS_BUSY_BIT     = 5;   // Sampler running
    localparam int STATUS_FW_LSB       = 24;  // FW_VERSION byte
    // Remaining status bits read as zero

    // Control word layout
    localparam int CONTROL_LED_BIT  = 0;
    localparam int CONTROL_EMIO_LSB = 16;
    localparam int CONTROL_EMIO_W   = 16;  // EMIO byte field, bits 31:16
    // Bits 15:1 not stored

    // EMIO output width toward the PS side
    localparam int EMIO_W = 64;

    // Sample buffer entry 0 layout
    localparam int SEQ_LSB = 16;  // Sequence count in 31:16
    localparam int SEQ_W   = 16;

    // Upper bound on snapshot quadlets after the sequence word
    localparam int MAX_RT_READ_QUADS = 4;

endpackage

`default_nettype wire

// File: verilog/bcfg_regs.sv
// Register block serving host reads and writes of status, control, inputs and scratch
`default_nettype none

module bcfg_regs (
    input  logic                                sysclk,
    input  logic                                arst_n,
    input  logic [bcfg_pkg::BOARD_ID_W-1:0]     board_id,
    input  bcfg_pkg::quad_t                     io_in,
    input  logic [bcfg_pkg::ADDR_W-1:0]         reg_raddr,
    output bcfg_pkg::quad_t                     reg_rdata,
    input  logic [bcfg_pkg::ADDR_W-1:0]         reg_waddr,
    input  bcfg_pkg::quad_t                     reg_wdata,
    input  logic                                reg_wen,
    input  logic                                blk_wstart,
    input  logic                                blk_wen,
    input  logic                                sample_busy,
    snapshot_if.src                             snap,
    output logic [bcfg_pkg::EMIO_W-1:0]         reg_emio,
    output logic                                led
);

    localparam int SCR_IDX_W = $clog2(bcfg_pkg::NUM_SCRATCH);

    bcfg_pkg::quad_t timestamp;  // Free-running counter
    bcfg_pkg::quad_t io_in_q;    // One register stage on the inputs
    logic            ctrl_led;
    logic [bcfg_pkg::CONTROL_EMIO_W-1:0] ctrl_emio;
    bcfg_pkg::quad_t scratch [bcfg_pkg::NUM_SCRATCH];

    logic [bcfg_pkg::ADDR_W-1:0] blk_ptr;    // Block write pointer
    logic [bcfg_pkg::ADDR_W-1:0] scr_waddr;  // Write address, single or block
    logic [bcfg_pkg::ADDR_W-1:0] scr_woff;
    logic [bcfg_pkg::ADDR_W-1:0] scr_roff;
    logic                        scr_wen;
    logic                        scr_rsel;
    logic                        ctrl_wen;

    bcfg_pkg::quad_t status;
    bcfg_pkg::quad_t control;
    bcfg_pkg::quad_t rd_mux;

    // Write decode
    always_comb begin
        scr_waddr = blk_wen ? blk_ptr : reg_waddr;  // Block pointer wins during blk_wen
        scr_woff  = scr_waddr - bcfg_pkg::REG_SCRATCH_BASE;
        scr_wen   = (reg_wen || blk_wen)
                    && (scr_waddr >= bcfg_pkg::REG_SCRATCH_BASE)
                    && (scr_waddr < bcfg_pkg::REG_SCRATCH_BASE + bcfg_pkg::NUM_SCRATCH);
        // Block writes never reach control
        ctrl_wen  = reg_wen && (reg_waddr == bcfg_pkg::REG_CONTROL);
    end

    // Control register, stored fields only
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_led  <= 1'b0;
            ctrl_emio <= '0;
        end else if (ctrl_wen) begin
            ctrl_led  <= reg_wdata[bcfg_pkg::CONTROL_LED_BIT];
            ctrl_emio <= reg_wdata[bcfg_pkg::CONTROL_EMIO_LSB +: bcfg_pkg::CONTROL_EMIO_W];
        end
    end

    // Scratch array
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bcfg_pkg::NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
        end else if (scr_wen) begin
            scratch[scr_woff[SCR_IDX_W-1:0]] <= reg_wdata;
        end
    end

    // Block pointer, advances even when the target is dropped
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            blk_ptr <= '0;
        end else if (blk_wstart) begin
            blk_ptr <= reg_waddr;  // Latch start address
        end else if (blk_wen) begin
            blk_ptr <= blk_ptr + 1'b1;
        end
    end

    // Timestamp and input stage
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
            io_in_q   <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;  // Wraps
            io_in_q   <= io_in;
        end
    end

    // Status and control words as seen by the host
    always_comb begin
        status = '0;
        status[bcfg_pkg::STATUS_BOARD_ID_LSB +: bcfg_pkg::BOARD_ID_W] = board_id;
        status[bcfg_pkg::STATUS_LED_BIT]                              = ctrl_led;
        status[bcfg_pkg::STATUS_BUSY_BIT]                             = sample_busy;
        status[bcfg_pkg::STATUS_FW_LSB +: 8]                          = bcfg_pkg::FW_VERSION;

        control = '0;  // Unstored bits read 0
        control[bcfg_pkg::CONTROL_LED_BIT]                              = ctrl_led;
        control[bcfg_pkg::CONTROL_EMIO_LSB +: bcfg_pkg::CONTROL_EMIO_W] = ctrl_emio;
    end

    // Read address decode
    assign scr_roff = reg_raddr - bcfg_pkg::REG_SCRATCH_BASE;
    assign scr_rsel = (reg_raddr >= bcfg_pkg::REG_SCRATCH_BASE)
                      && (reg_raddr < bcfg_pkg::REG_SCRATCH_BASE + bcfg_pkg::NUM_SCRATCH);

    always_comb begin
        rd_mux = '0;  // Unmapped reads return 0
        if (scr_rsel) begin
            rd_mux = scratch[scr_roff[SCR_IDX_W-1:0]];
        end else begin
            case (reg_raddr)
                bcfg_pkg::REG_STATUS:    rd_mux = status;
                bcfg_pkg::REG_CONTROL:   rd_mux = control;
                bcfg_pkg::REG_IO_IN:     rd_mux = io_in_q;
                bcfg_pkg::REG_TIMESTAMP: rd_mux = timestamp;
                default:                 rd_mux = '0;
            endcase
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_mux;
        end
    end

    // Outputs
    assign led      = ctrl_led;
    assign reg_emio = {{(bcfg_pkg::EMIO_W - bcfg_pkg::CONTROL_EMIO_W){1'b0}}, ctrl_emio};

    // Live values for the sampler
    assign snap.timestamp = timestamp;
    assign snap.io_in     = io_in_q;
    assign snap.status    = status;
    assign snap.scratch0  = scratch[0];

endmodule

`default_nettype wire

// File: verilog/bcfg_sampler.sv
// Sampling engine that writes a sequence word and snapshot quadlets into a readable buffer
`default_nettype none

module bcfg_sampler #(
    parameter int NUM_RT_READ_QUADS = 4  // Quadlets after the sequence word
) (
    input  logic                                sysclk,
    input  logic                                arst_n,
    input  logic [bcfg_pkg::BOARD_ID_W-1:0]     board_id,
    input  logic                                sample_start,
    output logic                                sample_busy,
    input  logic [bcfg_pkg::SAMPLE_ADDR_W-1:0]  sample_raddr,
    output bcfg_pkg::quad_t                     sample_rdata,
    snapshot_if.snk                             snap
);

    localparam int NUM_ENTRIES = 1 + NUM_RT_READ_QUADS;  // Broadcast block size
    localparam int CNT_W       = $clog2(NUM_ENTRIES);
    localparam int MEM_DEPTH   = 2 ** bcfg_pkg::SAMPLE_ADDR_W;
    localparam int MAX_ENTRIES = 1 + bcfg_pkg::MAX_RT_READ_QUADS;

    // Only four live values exist to capture
    if (NUM_RT_READ_QUADS < 1 || NUM_RT_READ_QUADS > bcfg_pkg::MAX_RT_READ_QUADS) begin : g_bad_n
        $error("NUM_RT_READ_QUADS out of range 1..%0d", bcfg_pkg::MAX_RT_READ_QUADS);
    end

    logic [CNT_W-1:0]            ent_idx;  // Entry being written
    logic                        ent_last;
    logic                        start_ok;
    logic [bcfg_pkg::SEQ_W-1:0]  seq_cnt;  // Samples taken since reset
    bcfg_pkg::quad_t             entry [MAX_ENTRIES];
    bcfg_pkg::quad_t             wr_data;

    // Sample buffer, no reset
    bcfg_pkg::quad_t sample_mem [MEM_DEPTH];

    assign start_ok = sample_start && !sample_busy;  // Starts while busy dropped
    assign ent_last = (ent_idx == CNT_W'(NUM_RT_READ_QUADS));

    // Counter FSM, idle or walking entries 0..N
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            sample_busy <= 1'b0;
            ent_idx     <= '0;
            seq_cnt     <= '0;
        end else if (start_ok) begin
            sample_busy <= 1'b1;
            ent_idx     <= '0;
            seq_cnt     <= seq_cnt + 1'b1;  // First sample reports 1
        end else if (sample_busy) begin
            if (ent_last) begin
                sample_busy <= 1'b0;
                ent_idx     <= '0;
            end else begin
                ent_idx <= ent_idx + 1'b1;
            end
        end
    end

    // Candidate entries
    always_comb begin
        entry[0] = '0;
        entry[0][bcfg_pkg::SEQ_LSB +: bcfg_pkg::SEQ_W] = seq_cnt;
        entry[0][bcfg_pkg::BOARD_ID_W-1:0]             = board_id;
        entry[1] = snap.timestamp;
        entry[2] = snap.io_in;
        entry[3] = snap.status;    // Busy bit is set here
        entry[4] = snap.scratch0;
    end

    assign wr_data = entry[ent_idx];

    // Buffer write while busy, registered read port
    always_ff @(posedge sysclk) begin
        if (sample_busy) begin
            sample_mem[bcfg_pkg::SAMPLE_ADDR_W'(ent_idx)] <= wr_data;
        end
        sample_rdata <= sample_mem[sample_raddr];  // Old data on same-address write
    end

endmodule

`default_nettype wire

// File: verilog/bcfg_top.sv
// Top level of the boot configuration subsystem with registers, sampler and board id
`default_nettype none

module bcfg_top #(
    parameter int NUM_RT_READ_QUADS = 4  // Snapshot quadlets after sequence word
) (
    input  logic                                sysclk,
    input  logic                                arst_n,

    // Board I/O
    input  logic [bcfg_pkg::BOARD_ID_W-1:0]     wenid,     // Rotary switch, active low
    input  bcfg_pkg::quad_t                     io_in,
    output logic [bcfg_pkg::EMIO_W-1:0]         reg_emio,  // Feedback toward PS
    output logic                                led,

    // Host register bus
    input  logic [bcfg_pkg::ADDR_W-1:0]         reg_raddr,
    output bcfg_pkg::quad_t                     reg_rdata,
    input  logic [bcfg_pkg::ADDR_W-1:0]         reg_waddr,
    input  bcfg_pkg::quad_t                     reg_wdata,
    input  logic                                reg_wen,     // Single write strobe
    input  logic                                blk_wstart,  // Latch block start address
    input  logic                                blk_wen,     // Block write strobe

    // Sampling
    input  logic                                sample_start,
    output logic                                sample_busy,
    input  logic [bcfg_pkg::SAMPLE_ADDR_W-1:0]  sample_raddr,
    output bcfg_pkg::quad_t                     sample_rdata
);

    logic [bcfg_pkg::BOARD_ID_W-1:0] board_id;

    // Switch reads inverted
    assign board_id = ~wenid;

    // Live values from regs to sampler
    snapshot_if snap ();

    bcfg_regs u_regs (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .board_id    (board_id),
        .io_in       (io_in),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .blk_wstart  (blk_wstart),
        .blk_wen     (blk_wen),
        .sample_busy (sample_busy),  // Status busy bit
        .snap        (snap.src),
        .reg_emio    (reg_emio),
        .led         (led)
    );

    bcfg_sampler #(
        .NUM_RT_READ_QUADS (NUM_RT_READ_QUADS)
    ) u_sampler (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .board_id     (board_id),
        .sample_start (sample_start),
        .sample_busy  (sample_busy),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata),
        .snap         (snap.snk)
    );

endmodule

`default_nettype wire

// File: verilog/snapshot_if.sv
// Snapshot bundle with the live values that the sampler copies into its buffer
`default_nettype none

interface snapshot_if;

    bcfg_pkg::quad_t timestamp;  // Free-running cycle count
    bcfg_pkg::quad_t io_in;      // Registered input word
    bcfg_pkg::quad_t status;     // Live status word, busy bit included
    bcfg_pkg::quad_t scratch0;   // First scratch quadlet

    // Register block drives
    modport src (
        output timestamp,
        output io_in,
        output status,
        output scratch0
    );

    // Sampler only reads
    modport snk (
        input timestamp,
        input io_in,
        input status,
        input scratch0
    );

endinterface

`default_nettype wire
